// ==== design/mem_init_config.svh ====
/*
 * Memory bring-up sequencer parameters.
 * Memory and image sizes, access latency and bus widths.
 */
`ifndef MEM_INIT_CONFIG_SVH
`define MEM_INIT_CONFIG_SVH

// memory geometry, in 32-bit words
`define MEM_WORDS   64
`define IMAGE_WORDS 24     // at most MEM_WORDS

// cycles of busy per access
`define MEM_LATENCY 3

// byte address and data widths
`define ADDR_W      8
`define DATA_W      32

`endif

// ==== design/mem_init_pkg.sv ====
/*
 * Memory bring-up package.
 * Phase and engine state encodings, address and data types.
 */
`default_nettype none

package mem_init_pkg;

`include "mem_init_config.svh"

    // bring-up phases in order
    typedef enum logic [1:0] {
        PH_ZERO,
        PH_LOAD,
        PH_VERIFY,
        PH_RUN
    } init_phase_e;

    // strobe / wait handshake shared by the engines
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,   // strobe up, waiting for busy
        ST_WAIT     // busy seen, waiting for it to fall
    } eng_state_e;

    typedef logic [`ADDR_W-1:0] addr_t;   // byte address, low two bits ignored
    typedef logic [`DATA_W-1:0] word_t;

endpackage

`default_nettype wire

// ==== design/word_mem.sv ====
/*
 * Word memory model.
 * Accepts one access while idle, then holds busy for a fixed latency.
 */
`timescale 1ns/1ps
`default_nettype none
`include "mem_init_config.svh"

module word_mem (
    input  wire                      clk,
    input  wire                      i_rst_n,
    input  wire                      i_wr,
    input  wire                      i_rd,
    input  wire mem_init_pkg::addr_t i_addr,
    input  wire mem_init_pkg::word_t i_wdata,
    output mem_init_pkg::word_t      o_rdata,
    output logic                     o_busy
);
    import mem_init_pkg::*;

    localparam int WA_W  = $clog2(`MEM_WORDS);
    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    word_t            mem [`MEM_WORDS];
    logic [WA_W-1:0]  word_addr;
    logic [WA_W-1:0]  rd_addr;    // read in flight
    logic             rd_pend;
    logic [CNT_W-1:0] lat_cnt;
    logic             accept;

    assign word_addr = i_addr[WA_W+1:2];
    assign o_busy    = (lat_cnt != '0);
    assign accept    = !o_busy && (i_wr || i_rd);   // strobes ignored while busy

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            lat_cnt <= '0;
            rd_pend <= 1'b0;
        end else if (accept) begin
            lat_cnt <= CNT_W'(`MEM_LATENCY);
            rd_pend <= !i_wr;    // write wins if both are up
        end else if (o_busy) begin
            lat_cnt <= lat_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && i_wr)
            mem[word_addr] <= i_wdata;
        if (accept)
            rd_addr <= word_addr;
        if (rd_pend && lat_cnt == CNT_W'(1))
            o_rdata <= mem[rd_addr];   // valid as busy falls
    end

endmodule

`default_nettype wire

// ==== design/zero_fill.sv ====
/*
 * Zero-fill engine.
 * Writes zero to every memory word during the clear phase.
 */
`timescale 1ns/1ps
`default_nettype none
`include "mem_init_config.svh"

module zero_fill (
    input  wire                 clk,
    input  wire                 i_rst_n,
    input  wire                 i_start,
    input  wire                 i_mem_busy,
    output logic                o_req_wr,
    output mem_init_pkg::addr_t o_req_addr,
    output logic                o_done
);
    import mem_init_pkg::*;

    localparam addr_t LAST_ADDR = addr_t'((`MEM_WORDS - 1) * 4);

    eng_state_e state;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state      <= ST_IDLE;
            o_req_wr   <= 1'b0;
            o_req_addr <= '0;
            o_done     <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (i_start && !o_done && !i_mem_busy) begin
                    o_req_wr <= 1'b1;
                    state    <= ST_ISSUE;
                end
                ST_ISSUE: if (i_mem_busy) begin
                    o_req_wr <= 1'b0;    // accepted
                    state    <= ST_WAIT;
                end
                ST_WAIT: if (!i_mem_busy) begin
                    if (o_req_addr == LAST_ADDR)
                        o_done <= 1'b1;
                    o_req_addr <= o_req_addr + addr_t'(4);
                    state      <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/stream_loader.sv ====
/*
 * Stream loader engine.
 * Writes incoming image words at ascending addresses and keeps their sum.
 */
`timescale 1ns/1ps
`default_nettype none
`include "mem_init_config.svh"

module stream_loader (
    input  wire                      clk,
    input  wire                      i_rst_n,
    input  wire                      i_start,
    input  wire                      i_ld_valid,
    input  wire mem_init_pkg::word_t i_ld_data,
    output logic                     o_ld_ready,
    input  wire                      i_mem_busy,
    output logic                     o_req_wr,
    output mem_init_pkg::addr_t      o_req_addr,
    output mem_init_pkg::word_t      o_req_wdata,
    output mem_init_pkg::word_t      o_sum,
    output logic                     o_done
);
    import mem_init_pkg::*;

    localparam addr_t LAST_ADDR = addr_t'((`IMAGE_WORDS - 1) * 4);

    eng_state_e state;

    // only take a word when nothing is in flight
    assign o_ld_ready = i_start && !o_done && (state == ST_IDLE) && !i_mem_busy;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state      <= ST_IDLE;
            o_req_wr   <= 1'b0;
            o_req_addr <= '0;
            o_sum      <= '0;
            o_done     <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (i_ld_valid && o_ld_ready) begin
                    o_sum    <= o_sum + i_ld_data;    // wraps at 32 bits
                    o_req_wr <= 1'b1;
                    state    <= ST_ISSUE;
                end
                ST_ISSUE: if (i_mem_busy) begin
                    o_req_wr <= 1'b0;
                    state    <= ST_WAIT;
                end
                ST_WAIT: if (!i_mem_busy) begin
                    if (o_req_addr == LAST_ADDR)
                        o_done <= 1'b1;
                    o_req_addr <= o_req_addr + addr_t'(4);
                    state      <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // write data latched with the accepted word
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_ld_valid && o_ld_ready)
            o_req_wdata <= i_ld_data;
    end

endmodule

`default_nettype wire

// ==== design/readback_verify.sv ====
/*
 * Read-back verifier.
 * Reads the image region back in order and sums the words.
 */
`timescale 1ns/1ps
`default_nettype none
`include "mem_init_config.svh"

module readback_verify (
    input  wire                      clk,
    input  wire                      i_rst_n,
    input  wire                      i_start,
    input  wire                      i_mem_busy,
    input  wire mem_init_pkg::word_t i_mem_rdata,
    output logic                     o_req_rd,
    output mem_init_pkg::addr_t      o_req_addr,
    output mem_init_pkg::word_t      o_sum,
    output logic                     o_done
);
    import mem_init_pkg::*;

    localparam addr_t LAST_ADDR = addr_t'((`IMAGE_WORDS - 1) * 4);

    eng_state_e state;
    logic       last_word;

    assign last_word = (o_req_addr == LAST_ADDR);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state      <= ST_IDLE;
            o_req_rd   <= 1'b0;
            o_req_addr <= '0;
            o_sum      <= '0;
            o_done     <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (i_start && !o_done && !i_mem_busy) begin
                    o_req_rd <= 1'b1;
                    state    <= ST_ISSUE;
                end
                ST_ISSUE: if (i_mem_busy) begin
                    o_req_rd <= 1'b0;
                    state    <= ST_WAIT;
                end
                ST_WAIT: if (!i_mem_busy) begin
                    // read data is valid on the falling edge of busy
                    o_sum      <= o_sum + i_mem_rdata;
                    o_req_addr <= o_req_addr + addr_t'(4);
                    state      <= ST_IDLE;
                    if (last_word)
                        o_done <= 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/init_arbiter.sv ====
/*
 * Bring-up arbiter.
 * Steps through the phases and steers the memory port to the active peer,
 * then to the user port once bring-up is over.
 */
`timescale 1ns/1ps
`default_nettype none

module init_arbiter (
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire                       i_zero_done,
    input  wire                       i_load_done,
    input  wire                       i_verify_done,
    output mem_init_pkg::init_phase_e o_phase,
    input  wire                       i_zero_wr,
    input  wire mem_init_pkg::addr_t  i_zero_addr,
    input  wire                       i_load_wr,
    input  wire mem_init_pkg::addr_t  i_load_addr,
    input  wire mem_init_pkg::word_t  i_load_wdata,
    input  wire                       i_ver_rd,
    input  wire mem_init_pkg::addr_t  i_ver_addr,
    input  wire                       i_user_rd,
    input  wire                       i_user_wr,
    input  wire mem_init_pkg::addr_t  i_user_addr,
    input  wire mem_init_pkg::word_t  i_user_wdata,
    input  wire                       i_mem_busy,
    output logic                      o_mem_wr,
    output logic                      o_mem_rd,
    output mem_init_pkg::addr_t       o_mem_addr,
    output mem_init_pkg::word_t       o_mem_wdata,
    output logic                      o_user_busy,
    output logic                      o_init_done
);
    import mem_init_pkg::*;

    // phase advances the cycle after the engine's done
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_phase <= PH_ZERO;
        end else begin
            case (o_phase)
                PH_ZERO:   if (i_zero_done)   o_phase <= PH_LOAD;
                PH_LOAD:   if (i_load_done)   o_phase <= PH_VERIFY;
                PH_VERIFY: if (i_verify_done) o_phase <= PH_RUN;
                default:   o_phase <= PH_RUN;   // stays in run
            endcase
        end
    end

    always_comb begin
        o_mem_wr    = 1'b0;
        o_mem_rd    = 1'b0;
        o_mem_addr  = '0;
        o_mem_wdata = '0;    // zero-fill data
        case (o_phase)
            PH_ZERO: begin
                o_mem_wr   = i_zero_wr;
                o_mem_addr = i_zero_addr;
            end
            PH_LOAD: begin
                o_mem_wr    = i_load_wr;
                o_mem_addr  = i_load_addr;
                o_mem_wdata = i_load_wdata;
            end
            PH_VERIFY: begin
                o_mem_rd   = i_ver_rd;
                o_mem_addr = i_ver_addr;
            end
            default: begin
                o_mem_wr    = i_user_wr;
                o_mem_rd    = i_user_rd;
                o_mem_addr  = i_user_addr;
                o_mem_wdata = i_user_wdata;
            end
        endcase
    end

    assign o_init_done = (o_phase == PH_RUN);
    assign o_user_busy = o_init_done ? i_mem_busy : 1'b1;   // held busy during bring-up

endmodule

`default_nettype wire

// ==== design/mem_init_top.sv ====
/*
 * Memory bring-up sequencer top.
 * Zero-fill, stream load and read-back verify share one memory through
 * the arbiter, which hands it to the user port afterwards.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_init_top (
    input  wire                      clk,
    input  wire                      i_rst_n,
    input  wire                      i_ld_valid,
    input  wire mem_init_pkg::word_t i_ld_data,
    output logic                     o_ld_ready,
    input  wire                      i_user_rd,
    input  wire                      i_user_wr,
    input  wire mem_init_pkg::addr_t i_user_addr,
    input  wire mem_init_pkg::word_t i_user_wdata,
    output mem_init_pkg::word_t      o_user_rdata,
    output logic                     o_user_busy,
    output logic                     o_init_done,
    output mem_init_pkg::word_t      o_load_sum,
    output mem_init_pkg::word_t      o_verify_sum,
    output logic                     o_checksum_match
);
    import mem_init_pkg::*;

    init_phase_e phase;
    logic        zero_wr, zero_done, load_wr, load_done, ver_rd, ver_done;
    addr_t       zero_addr, load_addr, ver_addr, mem_addr;
    word_t       load_wdata, mem_wdata, mem_rdata;
    logic        mem_wr, mem_rd, mem_busy;

    zero_fill u_zero (
        .clk(clk), .i_rst_n(i_rst_n), .i_start(phase == PH_ZERO),
        .i_mem_busy(mem_busy), .o_req_wr(zero_wr), .o_req_addr(zero_addr),
        .o_done(zero_done)
    );

    stream_loader u_load (
        .clk(clk), .i_rst_n(i_rst_n), .i_start(phase == PH_LOAD),
        .i_ld_valid(i_ld_valid), .i_ld_data(i_ld_data), .o_ld_ready(o_ld_ready),
        .i_mem_busy(mem_busy), .o_req_wr(load_wr), .o_req_addr(load_addr),
        .o_req_wdata(load_wdata), .o_sum(o_load_sum), .o_done(load_done)
    );

    readback_verify u_verify (
        .clk(clk), .i_rst_n(i_rst_n), .i_start(phase == PH_VERIFY),
        .i_mem_busy(mem_busy), .i_mem_rdata(mem_rdata), .o_req_rd(ver_rd),
        .o_req_addr(ver_addr), .o_sum(o_verify_sum), .o_done(ver_done)
    );

    init_arbiter u_arb (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_zero_done(zero_done), .i_load_done(load_done), .i_verify_done(ver_done),
        .o_phase(phase),
        .i_zero_wr(zero_wr), .i_zero_addr(zero_addr),
        .i_load_wr(load_wr), .i_load_addr(load_addr), .i_load_wdata(load_wdata),
        .i_ver_rd(ver_rd), .i_ver_addr(ver_addr),
        .i_user_rd(i_user_rd), .i_user_wr(i_user_wr),
        .i_user_addr(i_user_addr), .i_user_wdata(i_user_wdata),
        .i_mem_busy(mem_busy),
        .o_mem_wr(mem_wr), .o_mem_rd(mem_rd), .o_mem_addr(mem_addr),
        .o_mem_wdata(mem_wdata),
        .o_user_busy(o_user_busy), .o_init_done(o_init_done)
    );

    word_mem u_mem (
        .clk(clk), .i_rst_n(i_rst_n), .i_wr(mem_wr), .i_rd(mem_rd),
        .i_addr(mem_addr), .i_wdata(mem_wdata), .o_rdata(mem_rdata),
        .o_busy(mem_busy)
    );

    assign o_user_rdata = mem_rdata;

    // latched once the verifier has seen the last word
    always_ff @(posedge clk) begin
        if (!i_rst_n)
            o_checksum_match <= 1'b0;
        else
            o_checksum_match <= ver_done && (o_load_sum == o_verify_sum);
    end

endmodule

`default_nettype wire

// ==== tests/tb_mem_init.sv ====
/*
 * Testbench for the memory bring-up sequencer.
 * Feeds an LCG image through the loader, checks both checksums, then
 * exercises the memory through the user port.
 */
`timescale 1ns/1ps
`default_nettype none
`include "mem_init_config.svh"

module tb_mem_init;
    import mem_init_pkg::*;

    localparam int TIMEOUT = 2000;   // cycles allowed per wait

    logic  clk;
    logic  i_rst_n;
    logic  i_ld_valid;
    word_t i_ld_data;
    logic  o_ld_ready;
    logic  i_user_rd;
    logic  i_user_wr;
    addr_t i_user_addr;
    word_t i_user_wdata;
    word_t o_user_rdata;
    logic  o_user_busy;
    logic  o_init_done;
    word_t o_load_sum;
    word_t o_verify_sum;
    logic  o_checksum_match;

    word_t image [`IMAGE_WORDS];   // words fed to the loader
    word_t lcg_state;
    word_t exp_sum;
    word_t rd_word;
    word_t wr_val;
    addr_t wr_addr;
    int    err_count;
    int    timeout_count;
    logic  aborted;                // set once any wait has timed out

    mem_init_top dut0 (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_ld_valid       (i_ld_valid),
        .i_ld_data        (i_ld_data),
        .o_ld_ready       (o_ld_ready),
        .i_user_rd        (i_user_rd),
        .i_user_wr        (i_user_wr),
        .i_user_addr      (i_user_addr),
        .i_user_wdata     (i_user_wdata),
        .o_user_rdata     (o_user_rdata),
        .o_user_busy      (o_user_busy),
        .o_init_done      (o_init_done),
        .o_load_sum       (o_load_sum),
        .o_verify_sum     (o_verify_sum),
        .o_checksum_match (o_checksum_match)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t lcg_next(input word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected checksum wrapping at 32 bits
    function automatic word_t image_sum(input int n);
        word_t acc;
        acc = '0;
        for (int k = 0; k < n; k++)
            acc = acc + image[k];
        return acc;
    endfunction

    task automatic check_value(input string name, input word_t exp, input word_t act);
        if (!aborted && exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_bringup_levels();
        check_value("user busy during bring-up", word_t'(1'b1), word_t'(o_user_busy));
        check_value("init done during bring-up", word_t'(1'b0), word_t'(o_init_done));
    endtask

    task automatic wait_ready();
        int cnt;
        cnt = 0;
        while (!aborted && !o_ld_ready && cnt < TIMEOUT) begin
            check_bringup_levels();
            @(negedge clk);
            cnt++;
        end
        if (cnt >= TIMEOUT) begin
            $display("Timeout: the loader never raised its ready level");
            timeout_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_init_done();
        int cnt;
        cnt = 0;
        while (!aborted && !o_init_done && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (cnt >= TIMEOUT) begin
            $display("Timeout: bring-up never finished");
            timeout_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_user_idle();
        int cnt;
        cnt = 0;
        while (!aborted && o_user_busy && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (cnt >= TIMEOUT) begin
            $display("Timeout: the user port stayed busy");
            timeout_count++;
            aborted = 1'b1;
        end
    endtask

    // strobe for one cycle, then wait for busy to fall
    task automatic user_write(input addr_t a, input word_t d);
        wait_user_idle();
        i_user_wr    = 1'b1;
        i_user_addr  = a;
        i_user_wdata = d;
        @(negedge clk);
        i_user_wr = 1'b0;
        wait_user_idle();
    endtask

    task automatic user_read(input addr_t a, output word_t d);
        wait_user_idle();
        i_user_rd   = 1'b1;
        i_user_addr = a;
        @(negedge clk);
        i_user_rd = 1'b0;
        wait_user_idle();
        d = o_user_rdata;    // valid once busy has fallen
    endtask

    initial begin
        i_rst_n       = 1'b0;
        i_ld_valid    = 1'b0;
        i_ld_data     = '0;
        i_user_rd     = 1'b0;
        i_user_wr     = 1'b0;
        i_user_addr   = '0;
        i_user_wdata  = '0;
        err_count     = 0;
        timeout_count = 0;
        aborted       = 1'b0;
        lcg_state     = 32'd44;

        // nonzero power-up contents for the clear phase to wipe
        for (int k = 0; k < `MEM_WORDS; k++)
            dut0.u_mem.mem[k] = 32'hdead_0000 | word_t'(k);

        repeat (2) @(negedge clk);
        i_rst_n = 1'b1;

        check_bringup_levels();
        check_value("ready after reset", word_t'(1'b0), word_t'(o_ld_ready));
        check_value("match after reset", word_t'(1'b0), word_t'(o_checksum_match));

        // image stream with one word per ready window
        for (int k = 0; k < `IMAGE_WORDS; k++) begin
            lcg_state = lcg_next(lcg_state);
            image[k]  = lcg_state;
            wait_ready();
            check_bringup_levels();
            i_ld_valid = 1'b1;
            i_ld_data  = image[k];
            @(negedge clk);
            i_ld_valid = 1'b0;
        end

        wait_init_done();
        exp_sum = image_sum(`IMAGE_WORDS);
        check_value("load sum", exp_sum, o_load_sum);
        check_value("verify sum", exp_sum, o_verify_sum);
        check_value("checksum match", word_t'(1'b1), word_t'(o_checksum_match));

        // late loader words must be dropped
        for (int k = 0; k < 3; k++) begin
            lcg_state  = lcg_next(lcg_state);
            i_ld_valid = 1'b1;
            i_ld_data  = lcg_state;
            @(negedge clk);
            i_ld_valid = 1'b0;
            @(negedge clk);
        end
        check_value("load sum after late words", exp_sum, o_load_sum);

        for (int k = 0; k < `IMAGE_WORDS; k++) begin
            user_read(addr_t'(k * 4), rd_word);
            check_value($sformatf("image word %0d", k), image[k], rd_word);
        end
        // also catches a late word written past the image
        for (int k = `IMAGE_WORDS; k < `MEM_WORDS; k++) begin
            user_read(addr_t'(k * 4), rd_word);
            check_value($sformatf("zero word %0d", k), '0, rd_word);
        end

        for (int k = 0; k < 4; k++) begin
            lcg_state = lcg_next(lcg_state);
            wr_addr   = addr_t'(((lcg_state >> 8) % `MEM_WORDS) * 4);
            lcg_state = lcg_next(lcg_state);
            wr_val    = lcg_state;
            user_write(wr_addr, wr_val);
            user_read(wr_addr, rd_word);
            check_value($sformatf("user write at %h", wr_addr), wr_val, rd_word);
        end

        $display("errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+design
design/mem_init_pkg.sv
design/word_mem.sv
design/zero_fill.sv
design/stream_loader.sv
design/readback_verify.sv
design/init_arbiter.sv
design/mem_init_top.sv
tests/tb_mem_init.sv

// ==== Makefile ====
VERILATOR = verilator
FLIST     = flist.f
TOP       = tb_mem_init
RTL_TOP   = mem_init_top
BUILD_DIR = obj_dir
LOG       = sim.log
VFLAGS    = --binary --timing -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
LINTFLAGS = --lint-only -Wall --top-module $(RTL_TOP) +incdir+design

SRCS      = $(shell grep -v '^+' $(FLIST))
RTL_SRCS  = $(filter design/%,$(SRCS))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SRCS) design/mem_init_config.svh $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "no result in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
